/* common/muldiv_pkg.sv */
`default_nettype none

package muldiv_pkg;

    localparam int XLEN = 32;

    // One operand or result word
    typedef logic [XLEN-1:0] xlen_t;

    // Full product of two sign-extended XLEN+1 bit operands
    typedef logic signed [2*XLEN+1:0] dword_t;

    typedef enum logic [2:0] {
        MUL    = 3'd0,
        MULH   = 3'd1,
        MULHSU = 3'd2,
        MULHU  = 3'd3,
        DIV    = 3'd4,
        DIVU   = 3'd5,
        REM    = 3'd6,
        REMU   = 3'd7
    } muldiv_op_e;

    function automatic logic is_mul_op(muldiv_op_e op);
        return op inside {MUL, MULH, MULHSU, MULHU};
    endfunction

    // Upper half of the product is returned
    function automatic logic is_high_op(muldiv_op_e op);
        return op inside {MULH, MULHSU, MULHU};
    endfunction

    function automatic logic is_signed_a(muldiv_op_e op);
        return op inside {MULH, MULHSU, DIV, REM};
    endfunction

    // MULHSU treats rs2 as unsigned
    function automatic logic is_signed_b(muldiv_op_e op);
        return op inside {MULH, DIV, REM};
    endfunction

    function automatic logic is_rem_op(muldiv_op_e op);
        return op inside {REM, REMU};
    endfunction

endpackage

`default_nettype wire

/* common/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    import muldiv_pkg::*;

    localparam int UUID_W    = 8;
    localparam int NUM_WARPS = 4;
    localparam int WID_W     = $clog2(NUM_WARPS);
    localparam int REG_IDX_W = 5;

    typedef logic [UUID_W-1:0]    uuid_t;
    typedef logic [WID_W-1:0]     wid_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // Travels with every instruction from issue to commit
    typedef struct packed {
        uuid_t    uuid;
        wid_t     wid;
        xlen_t    pc;
        reg_idx_t rd;
        logic     wb;
        // First and last packet of a split instruction
        logic     sop;
        logic     eop;
    } instr_tag_t;

endpackage

`default_nettype wire

/* muldiv/mul_pipe.sv */
`default_nettype none
`timescale 1ns/1ns

module mul_pipe
    import muldiv_pkg::*;
    import pipe_pkg::*;
#(
    parameter int NUM_LANES   = 2,
    parameter int MUL_LATENCY = 3
) (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        in_valid,
    output logic                        in_ready,
    input  instr_tag_t                  in_tag,
    input  logic [NUM_LANES-1:0]        in_tmask,
    input  muldiv_op_e                  in_op,
    input  xlen_t [NUM_LANES-1:0]       in_rs1,
    input  xlen_t [NUM_LANES-1:0]       in_rs2,

    output logic                        out_valid,
    input  logic                        out_ready,
    output instr_tag_t                  out_tag,
    output logic [NUM_LANES-1:0]        out_tmask,
    output xlen_t [NUM_LANES-1:0]       out_data
);

    localparam int LAST = MUL_LATENCY - 1;

    logic                       advance;
    dword_t [NUM_LANES-1:0]     prod_in;
    logic [MUL_LATENCY-1:0]     vld_r;
    logic [MUL_LATENCY-1:0]     high_r;
    instr_tag_t                 tag_r   [MUL_LATENCY];
    logic [NUM_LANES-1:0]       tmask_r [MUL_LATENCY];
    dword_t [NUM_LANES-1:0]     prod_r  [MUL_LATENCY];

    if (MUL_LATENCY < 1) begin : g_bad_latency
        $error("mul_pipe needs MUL_LATENCY of at least 1");
    end

    // The whole chain stalls together when the last stage is blocked
    assign advance  = out_ready || !out_valid;
    assign in_ready = advance;

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        logic signed [XLEN:0] op_a;
        logic signed [XLEN:0] op_b;

        assign op_a = {is_signed_a(in_op) && in_rs1[l][XLEN-1], in_rs1[l]};
        assign op_b = {is_signed_b(in_op) && in_rs2[l][XLEN-1], in_rs2[l]};
        assign prod_in[l] = op_a * op_b;

        assign out_data[l] = high_r[LAST] ? prod_r[LAST][l][2*XLEN-1:XLEN]
                                          : prod_r[LAST][l][XLEN-1:0];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_r <= '0;
        end else if (advance) begin
            vld_r[0] <= in_valid;
            for (int s = 1; s < MUL_LATENCY; s++) begin
                vld_r[s] <= vld_r[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            prod_r[0]  <= prod_in;
            tag_r[0]   <= in_tag;
            tmask_r[0] <= in_tmask;
            high_r[0]  <= is_high_op(in_op);
            for (int s = 1; s < MUL_LATENCY; s++) begin
                prod_r[s]  <= prod_r[s-1];
                tag_r[s]   <= tag_r[s-1];
                tmask_r[s] <= tmask_r[s-1];
                high_r[s]  <= high_r[s-1];
            end
        end
    end

    assign out_valid = vld_r[LAST];
    assign out_tag   = tag_r[LAST];
    assign out_tmask = tmask_r[LAST];

    a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(out_valid));

endmodule

`default_nettype wire

/* muldiv/serial_div.sv */
`default_nettype none
`timescale 1ns/1ns

module serial_div
    import muldiv_pkg::*;
#(
    parameter int NUM_LANES = 2
) (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    start,
    input  logic                    is_signed,
    input  xlen_t [NUM_LANES-1:0]   numer,
    input  xlen_t [NUM_LANES-1:0]   denom,

    output logic                    busy,
    output logic                    done,
    output xlen_t [NUM_LANES-1:0]   quotient,
    output xlen_t [NUM_LANES-1:0]   remainder
);

    localparam int STEPS = XLEN;

    logic [$clog2(STEPS):0]     cnt;
    logic [NUM_LANES-1:0]       neg_q;
    logic [NUM_LANES-1:0]       neg_r;
    logic [NUM_LANES-1:0]       dvz;
    xlen_t [NUM_LANES-1:0]      dvr;
    xlen_t [NUM_LANES-1:0]      acc;
    xlen_t [NUM_LANES-1:0]      quo;
    xlen_t [NUM_LANES-1:0]      abs_n;
    xlen_t [NUM_LANES-1:0]      abs_d;
    xlen_t [NUM_LANES-1:0]      nxt_acc;
    xlen_t [NUM_LANES-1:0]      nxt_quo;
    xlen_t [NUM_LANES-1:0]      fix_quo;
    xlen_t [NUM_LANES-1:0]      fix_rem;

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        logic [XLEN:0] trial;
        logic          fits;

        assign abs_n[l] = (is_signed && numer[l][XLEN-1]) ? -numer[l] : numer[l];
        assign abs_d[l] = (is_signed && denom[l][XLEN-1]) ? -denom[l] : denom[l];

        // Shift one dividend bit into the partial remainder and try to subtract
        assign trial      = {acc[l], quo[l][XLEN-1]};
        assign fits       = trial >= {1'b0, dvr[l]};
        assign nxt_acc[l] = fits ? xlen_t'(trial - {1'b0, dvr[l]}) : trial[XLEN-1:0];
        assign nxt_quo[l] = {quo[l][XLEN-2:0], fits};

        // With a zero divisor every step fits, so the remainder ends up as |numer|
        // and the sign fix restores the dividend. MIN / -1 wraps back to MIN by itself
        assign fix_quo[l] = dvz[l] ? '1 : (neg_q[l] ? -quo[l] : quo[l]);
        assign fix_rem[l] = neg_r[l] ? -acc[l] : acc[l];
    end

    assign done = busy && (cnt == STEPS);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= '0;
        end else if (done) begin
            busy <= 1'b0;
        end else if (busy) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            quo <= abs_n;
            dvr <= abs_d;
            acc <= '0;
            for (int l = 0; l < NUM_LANES; l++) begin
                neg_q[l] <= is_signed && (numer[l][XLEN-1] ^ denom[l][XLEN-1]);
                neg_r[l] <= is_signed && numer[l][XLEN-1];
                dvz[l]   <= (denom[l] == '0);
            end
        end else if (done) begin
            quo <= fix_quo;
            acc <= fix_rem;
        end else if (busy) begin
            quo <= nxt_quo;
            acc <= nxt_acc;
        end
    end

    assign quotient  = quo;
    assign remainder = acc;

    a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !busy);

endmodule

`default_nettype wire

/* muldiv/div_unit.sv */
`default_nettype none
`timescale 1ns/1ns

module div_unit
    import muldiv_pkg::*;
    import pipe_pkg::*;
#(
    parameter int NUM_LANES = 2
) (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    in_valid,
    output logic                    in_ready,
    input  instr_tag_t              in_tag,
    input  logic [NUM_LANES-1:0]    in_tmask,
    input  muldiv_op_e              in_op,
    input  xlen_t [NUM_LANES-1:0]   in_rs1,
    input  xlen_t [NUM_LANES-1:0]   in_rs2,

    output logic                    out_valid,
    input  logic                    out_ready,
    output instr_tag_t              out_tag,
    output logic [NUM_LANES-1:0]    out_tmask,
    output xlen_t [NUM_LANES-1:0]   out_data
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        HOLD
    } div_state_e;

    div_state_e             state;
    logic                   start;
    logic                   div_busy;
    logic                   div_done;
    logic                   rem_r;
    xlen_t [NUM_LANES-1:0]  quotient;
    xlen_t [NUM_LANES-1:0]  remainder;

    assign in_ready = (state == IDLE);
    assign start    = in_valid && in_ready;

    serial_div #(
        .NUM_LANES (NUM_LANES)
    ) u_serial_div (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .is_signed (is_signed_a(in_op)),
        .numer     (in_rs1),
        .denom     (in_rs2),
        .busy      (div_busy),
        .done      (div_done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (in_valid) state <= RUN;
                RUN:  if (div_done) state <= HOLD;
                HOLD: if (out_ready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            out_tag   <= in_tag;
            out_tmask <= in_tmask;
            rem_r     <= is_rem_op(in_op);
        end
    end

    assign out_valid = (state == HOLD);

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            out_data[l] = rem_r ? remainder[l] : quotient[l];
        end
    end

    // The divider keeps its result registers untouched until the next start
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (state == HOLD) && !out_ready |=> out_valid && $stable(out_data));

    a_run_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (state == RUN) |-> div_busy);

endmodule

`default_nettype wire

/* src/commit_arb.sv */
`default_nettype none
`timescale 1ns/1ns

module commit_arb
    import muldiv_pkg::*;
    import pipe_pkg::*;
#(
    parameter int NUM_LANES = 2
) (
    input  logic                            clk,
    input  logic                            rst_n,

    input  logic [1:0]                      in_valid,
    output logic [1:0]                      in_ready,
    input  instr_tag_t [1:0]                in_tag,
    input  logic [1:0][NUM_LANES-1:0]       in_tmask,
    input  xlen_t [1:0][NUM_LANES-1:0]      in_data,

    output logic                            out_valid,
    input  logic                            out_ready,
    output instr_tag_t                      out_tag,
    output logic [NUM_LANES-1:0]            out_tmask,
    output xlen_t [NUM_LANES-1:0]           out_data
);

    logic can_load;
    logic any_valid;
    logic prio;
    logic sel;

    // Output register refills in the same cycle it drains
    assign can_load  = !out_valid || out_ready;
    assign any_valid = |in_valid;

    // Favoured input wins if it has data, otherwise the other one
    assign sel = in_valid[prio] ? prio : !prio;

    assign in_ready[0] = can_load && in_valid[0] && (sel == 1'b0);
    assign in_ready[1] = can_load && in_valid[1] && (sel == 1'b1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            prio      <= 1'b0;
        end else if (can_load) begin
            out_valid <= any_valid;
            if (any_valid) begin
                prio <= !sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (can_load && any_valid) begin
            out_tag   <= in_tag[sel];
            out_tmask <= in_tmask[sel];
            out_data  <= in_data[sel];
        end
    end

    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(in_ready[0] && in_ready[1]));

endmodule

`default_nettype wire

/* src/muldiv_unit.sv */
`default_nettype none
`timescale 1ns/1ns

module muldiv_unit
    import muldiv_pkg::*;
    import pipe_pkg::*;
#(
    parameter int NUM_LANES   = 2,
    parameter int MUL_LATENCY = 3
) (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    req_valid,
    output logic                    req_ready,
    input  instr_tag_t              req_tag,
    input  muldiv_op_e              req_op,
    input  logic [NUM_LANES-1:0]    req_tmask,
    input  xlen_t [NUM_LANES-1:0]   req_rs1,
    input  xlen_t [NUM_LANES-1:0]   req_rs2,

    output logic                    commit_valid,
    input  logic                    commit_ready,
    output instr_tag_t              commit_tag,
    output logic [NUM_LANES-1:0]    commit_tmask,
    output xlen_t [NUM_LANES-1:0]   commit_data
);

    logic                   is_mul;
    logic                   mul_valid;
    logic                   mul_ready;
    logic                   div_valid;
    logic                   div_ready;
    logic                   mul_out_valid;
    logic                   mul_out_ready;
    instr_tag_t             mul_out_tag;
    logic [NUM_LANES-1:0]   mul_out_tmask;
    xlen_t [NUM_LANES-1:0]  mul_out_data;
    logic                   div_out_valid;
    logic                   div_out_ready;
    instr_tag_t             div_out_tag;
    logic [NUM_LANES-1:0]   div_out_tmask;
    xlen_t [NUM_LANES-1:0]  div_out_data;

    assign is_mul    = is_mul_op(req_op);
    assign mul_valid = req_valid && is_mul;
    assign div_valid = req_valid && !is_mul;
    assign req_ready = is_mul ? mul_ready : div_ready;

    mul_pipe #(
        .NUM_LANES   (NUM_LANES),
        .MUL_LATENCY (MUL_LATENCY)
    ) u_mul_pipe (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (mul_valid),
        .in_ready  (mul_ready),
        .in_tag    (req_tag),
        .in_tmask  (req_tmask),
        .in_op     (req_op),
        .in_rs1    (req_rs1),
        .in_rs2    (req_rs2),
        .out_valid (mul_out_valid),
        .out_ready (mul_out_ready),
        .out_tag   (mul_out_tag),
        .out_tmask (mul_out_tmask),
        .out_data  (mul_out_data)
    );

    div_unit #(
        .NUM_LANES (NUM_LANES)
    ) u_div_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (div_valid),
        .in_ready  (div_ready),
        .in_tag    (req_tag),
        .in_tmask  (req_tmask),
        .in_op     (req_op),
        .in_rs1    (req_rs1),
        .in_rs2    (req_rs2),
        .out_valid (div_out_valid),
        .out_ready (div_out_ready),
        .out_tag   (div_out_tag),
        .out_tmask (div_out_tmask),
        .out_data  (div_out_data)
    );

    // Input 0 is the multiplier, input 1 the divider
    commit_arb #(
        .NUM_LANES (NUM_LANES)
    ) u_commit_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  ({div_out_valid, mul_out_valid}),
        .in_ready  ({div_out_ready, mul_out_ready}),
        .in_tag    ({div_out_tag, mul_out_tag}),
        .in_tmask  ({div_out_tmask, mul_out_tmask}),
        .in_data   ({div_out_data, mul_out_data}),
        .out_valid (commit_valid),
        .out_ready (commit_ready),
        .out_tag   (commit_tag),
        .out_tmask (commit_tmask),
        .out_data  (commit_data)
    );

endmodule

`default_nettype wire

/* tb/muldiv_unit_tb.sv */
`default_nettype none
`timescale 1ns/1ns

module muldiv_unit_tb
    import muldiv_pkg::*;
    import pipe_pkg::*;
();

    localparam int NUM_LANES      = 2;
    localparam int MUL_LATENCY    = 3;
    localparam int NUM_VEC        = 28;
    // op, uuid, tmask, an rs1/rs2 pair per lane, one expected result per lane
    localparam int VEC_WORDS      = 3 + 3 * NUM_LANES;
    localparam int TIMEOUT_CYCLES = NUM_VEC * 40 + 200;

    logic                   clk;
    logic                   rst_n;
    logic                   req_valid;
    logic                   req_ready;
    instr_tag_t             req_tag;
    muldiv_op_e             req_op;
    logic [NUM_LANES-1:0]   req_tmask;
    xlen_t [NUM_LANES-1:0]  req_rs1;
    xlen_t [NUM_LANES-1:0]  req_rs2;
    logic                   commit_valid;
    logic                   commit_ready;
    instr_tag_t             commit_tag;
    logic [NUM_LANES-1:0]   commit_tmask;
    xlen_t [NUM_LANES-1:0]  commit_data;

    logic [31:0]            golden    [NUM_VEC*VEC_WORDS];
    instr_tag_t             exp_tag   [256];
    muldiv_op_e             exp_op    [256];
    logic [NUM_LANES-1:0]   exp_tmask [256];
    xlen_t [NUM_LANES-1:0]  exp_data  [256];
    logic [255:0]           expected_live;
    logic [255:0]           committed;
    int                     done_count;
    integer                 seed;

    muldiv_unit #(
        .NUM_LANES   (NUM_LANES),
        .MUL_LATENCY (MUL_LATENCY)
    ) dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_tag      (req_tag),
        .req_op       (req_op),
        .req_tmask    (req_tmask),
        .req_rs1      (req_rs1),
        .req_rs2      (req_rs2),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_tag   (commit_tag),
        .commit_tmask (commit_tmask),
        .commit_data  (commit_data)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("** Error: %s expected %0h actual %0h", name, expected, actual));
        end
    endtask

    // Tag fields other than uuid are filled from the uuid so every field is exercised
    function automatic instr_tag_t make_tag(input uuid_t id);
        instr_tag_t t;
        t.uuid = id;
        t.wid  = id[WID_W-1:0];
        t.pc   = 32'h0000_1000 + {22'd0, id, 2'b00};
        t.rd   = id[REG_IDX_W-1:0];
        t.wb   = 1'b1;
        t.sop  = id[0];
        t.eop  = 1'b1;
        return t;
    endfunction

    task automatic load_expected();
        int    base;
        uuid_t id;
        expected_live = '0;
        committed     = '0;
        if ($isunknown(golden[NUM_VEC*VEC_WORDS-1])) begin
            abort_run("golden vector file is missing or too short");
        end
        for (int v = 0; v < NUM_VEC; v++) begin
            base = v * VEC_WORDS;
            id   = uuid_t'(golden[base+1]);
            if (expected_live[id]) begin
                abort_run($sformatf("golden vector %0d repeats uuid %0h", v, id));
            end
            expected_live[id] = 1'b1;
            exp_tag[id]       = make_tag(id);
            exp_op[id]        = muldiv_op_e'(golden[base][2:0]);
            exp_tmask[id]     = golden[base+2][NUM_LANES-1:0];
            for (int l = 0; l < NUM_LANES; l++) begin
                exp_data[id][l] = golden[base+3+2*NUM_LANES+l];
            end
        end
    endtask

    // Holds the request until the DUT accepts it on a rising edge
    task automatic send_request(input int v);
        int                    base;
        xlen_t [NUM_LANES-1:0] rs1;
        xlen_t [NUM_LANES-1:0] rs2;
        base = v * VEC_WORDS;
        for (int l = 0; l < NUM_LANES; l++) begin
            rs1[l] = golden[base+3+2*l];
            rs2[l] = golden[base+4+2*l];
        end
        req_valid <= 1'b1;
        req_op    <= muldiv_op_e'(golden[base][2:0]);
        req_tag   <= make_tag(uuid_t'(golden[base+1]));
        req_tmask <= golden[base+2][NUM_LANES-1:0];
        req_rs1   <= rs1;
        req_rs2   <= rs2;
        @(posedge clk);
        while (!req_ready) @(posedge clk);
    endtask

    task automatic check_commit();
        uuid_t id;
        string name;
        if ($isunknown(commit_tag.uuid)) begin
            abort_run("commit carries an unknown uuid value");
        end
        id = commit_tag.uuid;
        if (!expected_live[id]) begin
            abort_run($sformatf("commit carries uuid %0h that was never requested", id));
        end
        if (committed[id]) begin
            abort_run($sformatf("uuid %0h committed more than once", id));
        end
        name = $sformatf("%s uuid %0h", exp_op[id].name(), id);
        check_value({name, " tag"}, 64'(exp_tag[id]), 64'(commit_tag));
        check_value({name, " tmask"}, 64'(exp_tmask[id]), 64'(commit_tmask));
        for (int l = 0; l < NUM_LANES; l++) begin
            if (exp_tmask[id][l]) begin
                check_value($sformatf("%s lane %0d", name, l),
                            64'(exp_data[id][l]), 64'(commit_data[l]));
            end
        end
        committed[id] = 1'b1;
        done_count++;
    endtask

    // Back-pressure holds commit_ready low on roughly one cycle in four
    always @(posedge clk) begin
        commit_ready <= ($random(seed) & 3) != 0;
    end

    always @(posedge clk) begin
        if (rst_n && commit_valid && commit_ready) begin
            check_commit();
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        abort_run($sformatf("watchdog expired after %0d cycles, results never arrived",
                            TIMEOUT_CYCLES));
    end

    initial begin
        seed         = 61;
        done_count   = 0;
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req_tag      = '0;
        req_op       = MUL;
        req_tmask    = '0;
        req_rs1      = '0;
        req_rs2      = '0;
        commit_ready = 1'b0;
        $readmemh("tb/muldiv_golden.hex", golden);
        load_expected();

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_value("after reset commit_valid", 64'd0, 64'(commit_valid));
        check_value("after reset req_ready", 64'd1, 64'(req_ready));

        for (int v = 0; v < NUM_VEC; v++) begin
            send_request(v);
        end
        req_valid <= 1'b0;

        wait (done_count == NUM_VEC);
        // A few more cycles so that a late duplicate commit is still caught
        repeat (10) @(posedge clk);
        if (committed == expected_live) begin
            $display("TEST PASS");
            $finish;
        end else begin
            abort_run("some requested results never committed");
        end
    end

endmodule

`default_nettype wire

/* tb/muldiv_golden.hex */
// op uuid tmask rs1_lane0 rs2_lane0 rs1_lane1 rs2_lane1 expected_lane0 expected_lane1
// op codes: 0 MUL, 1 MULH, 2 MULHSU, 3 MULHU, 4 DIV, 5 DIVU, 6 REM, 7 REMU
0 01 3 00000007 00000006 FFFFFFFF 00000005 0000002A FFFFFFFB
4 02 3 00000064 00000007 FFFFFF9C 00000007 0000000E FFFFFFF2
1 03 3 80000000 80000000 FFFFFFFF FFFFFFFF 40000000 00000000
3 04 3 FFFFFFFF FFFFFFFF 80000000 00000002 FFFFFFFE 00000001
2 05 3 FFFFFFFF FFFFFFFF 00000002 80000000 FFFFFFFF 00000001
6 06 3 FFFFFF9C 00000007 00000064 FFFFFFF9 FFFFFFFE 00000002
0 07 1 00010000 00010000 12345678 00000010 00000000 23456780
5 08 3 FFFFFFFF 00000002 00000064 00000000 7FFFFFFF FFFFFFFF
3 09 2 00000003 00000005 10000000 00000010 00000000 00000001
4 0A 3 00000005 00000000 80000000 FFFFFFFF FFFFFFFF 80000000
0 0B 3 FFFFFFFE FFFFFFFD 0000FFFF 0000FFFF 00000006 FFFE0001
6 0C 3 80000000 FFFFFFFF FFFFFFF6 00000000 00000000 FFFFFFF6
1 0D 3 7FFFFFFF 7FFFFFFF 80000000 00000001 3FFFFFFF FFFFFFFF
7 0E 3 00000064 00000007 FFFFFFFF 00000000 00000002 FFFFFFFF
2 0F 3 80000000 FFFFFFFF 00000001 FFFFFFFF 80000000 00000000
5 10 3 80000000 FFFFFFFF 0000002A 00000006 00000000 00000007
0 11 3 80000000 FFFFFFFF 00000000 12345678 80000000 00000000
4 12 3 FFFFFFF9 FFFFFFFE 00000007 FFFFFFFE 00000003 FFFFFFFD
3 13 3 12345678 00000100 00000000 FFFFFFFF 00000012 00000000
7 14 3 80000000 00000003 0000000A 0000000B 00000002 0000000A
1 15 3 FFFFFFF0 00000010 40000000 00000004 FFFFFFFF 00000001
6 16 2 00000011 00000005 FFFFFFEF FFFFFFFB 00000002 FFFFFFFE
2 17 3 FFFFFFFE 00000003 7FFFFFFF 00000002 FFFFFFFF 00000000
4 18 3 80000000 00000002 00000000 00000000 C0000000 FFFFFFFF
0 19 3 00000003 FFFFFFFF 00001000 00001000 FFFFFFFD 01000000
5 1A 3 00000064 0000000A FFFFFFFE FFFFFFFF 0000000A 00000000
3 1B 3 80000000 80000000 FFFFFFFF 00000002 40000000 00000001
6 1C 3 80000000 00000002 00000064 00000000 00000000 00000064

/* sources.f */
common/muldiv_pkg.sv
common/pipe_pkg.sv
muldiv/mul_pipe.sv
muldiv/serial_div.sv
muldiv/div_unit.sv
src/commit_arb.sv
src/muldiv_unit.sv
tb/muldiv_unit_tb.sv

/* run.sh */
#!/bin/sh
# Builds and runs the muldiv_unit testbench with Verilator.
# The exit status is nonzero when the testbench reports a failure.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module muldiv_unit_tb -Mdir obj_dir -f sources.f

./obj_dir/Vmuldiv_unit_tb
